//--- common/soc_bus_macros.svh
// ------------------------------
// Address map and sizing constants for the peripheral bus.
// Included by every file that decodes or sizes against the map.
// ------------------------------

`ifndef SOC_BUS_MACROS_SVH
`define SOC_BUS_MACROS_SVH

// Base bytes, compared against addr[31:24]
`define SOC_BASE_BRAM 8'h00
`define SOC_BASE_GPIO 8'h02

// On-chip memory depth in 32-bit words
`define SOC_BRAM_WORDS 256

// Number of GPIO pins
`define SOC_GPIO_WIDTH 32

// Cycles an unanswered transfer waits before the bus error
`define SOC_BUS_TIMEOUT 16

`endif

//--- common/soc_bus_pkg.sv
// ------------------------------
// Shared bus and GPIO vector types for the peripheral side of the SoC.
// Referenced by scoped name from the interface and the RTL blocks.
// ------------------------------

`include "soc_bus_macros.svh"

package soc_bus_pkg;

    // ------------------------------
    // Memory bus fields
    // ------------------------------
    // Byte address, top byte picks the peripheral
    typedef logic [31:0] addr_t;

    // One bus data word
    typedef logic [31:0] data_t;

    // Byte write strobes, all zero marks a read
    typedef logic [3:0] strb_t;

    // Peripheral base byte, addr bits 31:24
    typedef logic [7:0] base_t;

    // ------------------------------
    // GPIO
    // ------------------------------
    // One bit per pin
    typedef logic [`SOC_GPIO_WIDTH-1:0] gpio_t;

endpackage

//--- common/mem_bus_if.sv
// ------------------------------
// Packed memory bus between the master and one peripheral.
// One instance per peripheral so each return path stays separate.
// ------------------------------

`timescale 1ns/1ps

interface mem_bus_if;

    // Forward path, master to peripheral
    logic                valid;
    soc_bus_pkg::addr_t  addr;
    soc_bus_pkg::data_t  wdata;
    soc_bus_pkg::strb_t  wstrb;

    // Return path, one-cycle ready pulse with data
    logic                ready;
    soc_bus_pkg::data_t  rdata;

    // Bus master side
    modport master (output valid, addr, wdata, wstrb, input ready, rdata);

    // Peripheral answering in its address window
    modport periph (input valid, addr, wdata, wstrb, output ready, rdata);

    // Observer only, used by the return combiner
    modport monitor (input valid, addr, wdata, wstrb, ready, rdata);

endinterface

//--- bram/bram_port.sv
// ------------------------------
// On-chip word memory on the packed bus.
// Answers every transfer whose base byte is SOC_BASE_BRAM, one cycle later.
// ------------------------------

`timescale 1ns/1ps

`include "soc_bus_macros.svh"

module bram_port (
    input logic     clk,
    input logic     reset,
    mem_bus_if.periph bus
);

    // Word index width, offsets above the depth wrap
    localparam int ADDR_BITS = $clog2(`SOC_BRAM_WORDS);

    // ------------------------------
    // Storage
    // ------------------------------
    soc_bus_pkg::data_t mem [`SOC_BRAM_WORDS];

    soc_bus_pkg::base_t  base_byte;
    logic [ADDR_BITS-1:0] word_idx;
    logic                 sel;
    logic                 accept;
    logic                 is_write;

    // ------------------------------
    // Decode
    // ------------------------------
    assign base_byte = bus.addr[31:24];
    // Low bits of the word offset only
    assign word_idx  = bus.addr[2 +: ADDR_BITS];
    assign sel       = (base_byte == `SOC_BASE_BRAM);
    // Skip the cycle where our own ready is up, so a held valid is served once
    assign accept    = bus.valid && sel && !bus.ready;
    assign is_write  = |bus.wstrb;

    // Byte-wise write of the strobed lanes
    always_ff @(posedge clk) begin
        if (accept && is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.wstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // Ready pulse and read data
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.ready <= 1'b0;
            bus.rdata <= '0;
        end else begin
            bus.ready <= accept;
            // rdata held at zero outside a read answer, keeps the OR clean
            if (accept && !is_write) begin
                bus.rdata <= mem[word_idx];
            end else begin
                bus.rdata <= '0;
            end
        end
    end

endmodule

//--- gpio/gpio_port.sv
// ------------------------------
// GPIO register block on the packed bus.
// Word 0 output data, word 1 output enable, word 2 synchronized pin input.
// ------------------------------

`timescale 1ns/1ps

`include "soc_bus_macros.svh"

module gpio_port (
    input  logic               clk,
    input  logic               reset,
    mem_bus_if.periph          bus,
    input  soc_bus_pkg::gpio_t gpio_in,
    output soc_bus_pkg::gpio_t gpio_out,
    output soc_bus_pkg::gpio_t gpio_oe
);

    // ------------------------------
    // Register map, word offsets
    // ------------------------------
    localparam logic [21:0] REG_OUT = 22'd0;
    localparam logic [21:0] REG_OE  = 22'd1;
    localparam logic [21:0] REG_IN  = 22'd2;

    soc_bus_pkg::base_t base_byte;
    logic [21:0]        word;
    logic               sel;
    logic               accept;
    logic               is_write;

    soc_bus_pkg::gpio_t out_reg;
    soc_bus_pkg::gpio_t oe_reg;
    // Two-flop synchronizer on the pins
    soc_bus_pkg::gpio_t in_meta;
    soc_bus_pkg::gpio_t in_sync;

    assign base_byte = bus.addr[31:24];
    assign word      = bus.addr[23:2];
    assign sel       = (base_byte == `SOC_BASE_GPIO);
    // One answer per transfer, even with valid held through ready
    assign accept    = bus.valid && sel && !bus.ready;
    assign is_write  = |bus.wstrb;

    assign gpio_out = out_reg;
    assign gpio_oe  = oe_reg;

    // Pin input capture
    always_ff @(posedge clk) begin
        if (reset) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    // ------------------------------
    // Writable registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            out_reg <= '0;
            oe_reg  <= '0;
        end else if (accept && is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.wstrb[b]) begin
                    // Word 2 and above take the ack but no data
                    if (word == REG_OUT) out_reg[8*b +: 8] <= bus.wdata[8*b +: 8];
                    if (word == REG_OE)  oe_reg[8*b +: 8]  <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // Ready pulse and read mux
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.ready <= 1'b0;
            bus.rdata <= '0;
        end else begin
            bus.ready <= accept;
            bus.rdata <= '0;
            if (accept && !is_write) begin
                case (word)
                    REG_OUT: bus.rdata <= out_reg;
                    REG_OE:  bus.rdata <= oe_reg;
                    REG_IN:  bus.rdata <= in_sync;
                    // Unused words read as zero
                    default: bus.rdata <= '0;
                endcase
            end
        end
    end

endmodule

//--- logic/bus_return_mux.sv
// ------------------------------
// Combines the peripheral returns by OR and ends unanswered transfers.
// A transfer left waiting SOC_BUS_TIMEOUT cycles gets ready with bus_error.
// ------------------------------

`timescale 1ns/1ps

`include "soc_bus_macros.svh"

module bus_return_mux (
    input  logic               clk,
    input  logic               reset,
    mem_bus_if.monitor         mem_ret,
    mem_bus_if.monitor         gpio_ret,
    output logic               ready,
    output soc_bus_pkg::data_t rdata,
    output logic               bus_error
);

    localparam int CNT_BITS = $clog2(`SOC_BUS_TIMEOUT) + 1;

    logic                periph_ready;
    logic                any_ready;
    logic [CNT_BITS-1:0] wait_cnt;
    logic                err_pulse;

    // ------------------------------
    // Return combine
    // ------------------------------
    // Idle peripherals keep rdata at zero, so OR is enough
    assign periph_ready = mem_ret.ready | gpio_ret.ready;
    assign any_ready    = periph_ready | err_pulse;

    assign ready     = any_ready;
    assign rdata     = mem_ret.rdata | gpio_ret.rdata;
    assign bus_error = err_pulse;

    // ------------------------------
    // Unanswered transfer watchdog
    // ------------------------------
    // Both instances share the forward path, one valid is enough
    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt  <= '0;
            err_pulse <= 1'b0;
        end else begin
            err_pulse <= 1'b0;
            if (!mem_ret.valid || any_ready) begin
                // Idle or answered, start over
                wait_cnt <= '0;
            end else if (wait_cnt == CNT_BITS'(`SOC_BUS_TIMEOUT - 1)) begin
                // Last waiting cycle counted, close with an error next cycle
                wait_cnt  <= '0;
                err_pulse <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

endmodule

//--- logic/soc_periph_top.sv
// ------------------------------
// Peripheral subsystem top, memory plus GPIO behind one packed bus.
// The bus master drives the plain mem_* ports and waits for mem_ready.
// ------------------------------

`timescale 1ns/1ps

module soc_periph_top (
    input  logic               clk,
    input  logic               reset,
    // Packed memory bus from the master
    input  logic               mem_valid,
    input  soc_bus_pkg::addr_t mem_addr,
    input  soc_bus_pkg::data_t mem_wdata,
    input  soc_bus_pkg::strb_t mem_wstrb,
    output logic               mem_ready,
    output soc_bus_pkg::data_t mem_rdata,
    output logic               bus_error,
    // GPIO pins, split into directions
    input  soc_bus_pkg::gpio_t gpio_in,
    output soc_bus_pkg::gpio_t gpio_out,
    output soc_bus_pkg::gpio_t gpio_oe
);

    // One bus instance per peripheral
    mem_bus_if mem_if ();
    mem_bus_if gpio_if ();

    // ------------------------------
    // Forward path fan-out
    // ------------------------------
    assign mem_if.valid  = mem_valid;
    assign mem_if.addr   = mem_addr;
    assign mem_if.wdata  = mem_wdata;
    assign mem_if.wstrb  = mem_wstrb;

    assign gpio_if.valid = mem_valid;
    assign gpio_if.addr  = mem_addr;
    assign gpio_if.wdata = mem_wdata;
    assign gpio_if.wstrb = mem_wstrb;

    // ------------------------------
    // Peripherals and return path
    // ------------------------------
    bram_port u_bram (
        .clk   (clk),
        .reset (reset),
        .bus   (mem_if.periph)
    );

    gpio_port u_gpio (
        .clk      (clk),
        .reset    (reset),
        .bus      (gpio_if.periph),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    bus_return_mux u_ret (
        .clk       (clk),
        .reset     (reset),
        .mem_ret   (mem_if.monitor),
        .gpio_ret  (gpio_if.monitor),
        .ready     (mem_ready),
        .rdata     (mem_rdata),
        .bus_error (bus_error)
    );

endmodule

//--- bench/soc_bus_checker.sv
// ------------------------------
// Handshake assertions on the peripheral returns.
// Bound into bus_return_mux, sees both return paths and the combined answer.
// ------------------------------

`timescale 1ns/1ps

module soc_bus_checker (
    input logic               clk,
    input logic               reset,
    mem_bus_if.monitor        mem_ret,
    mem_bus_if.monitor        gpio_ret,
    input logic               ready,
    input soc_bus_pkg::data_t rdata,
    input logic               bus_error
);

    // Failed assertion count, read by the testbench at the end
    int fails = 0;

    // Ready is a one-cycle pulse per peripheral
    ready_pulse: assert property (@(posedge clk) disable iff (reset)
        (mem_ret.ready |=> !mem_ret.ready) and (gpio_ret.ready |=> !gpio_ret.ready))
        else begin
            fails++;
            $error("Peripheral ready high for two cycles in a row");
        end

    // Address windows never overlap
    ready_onehot: assert property (@(posedge clk) disable iff (reset)
        !(mem_ret.ready && gpio_ret.ready))
        else begin
            fails++;
            $error("Memory and GPIO ready high together");
        end

    // Error completion is still a completion, and carries no data
    error_ready: assert property (@(posedge clk) disable iff (reset)
        bus_error |-> ready && rdata == '0)
        else begin
            fails++;
            $error("bus_error without ready or with nonzero rdata");
        end

    // Idle return data stays zero so the OR is clean
    rdata_idle: assert property (@(posedge clk) disable iff (reset)
        (mem_ret.ready || mem_ret.rdata == '0) && (gpio_ret.ready || gpio_ret.rdata == '0))
        else begin
            fails++;
            $error("Peripheral rdata nonzero while its ready is low");
        end

endmodule

// One checker per return combiner
bind bus_return_mux soc_bus_checker chk0 (.*);

//--- bench/soc_periph_tb.sv
// ------------------------------
// Directed testbench, acts as bus master of the peripheral top.
// Memory model array mirrors the on-chip memory, LFSR feeds random traffic.
// ------------------------------

`timescale 1ns/1ps

`include "soc_bus_macros.svh"

module soc_periph_tb;

    logic clk, reset, mem_valid, mem_ready, bus_error;
    soc_bus_pkg::addr_t mem_addr;
    soc_bus_pkg::data_t mem_wdata, mem_rdata;
    soc_bus_pkg::strb_t mem_wstrb;
    soc_bus_pkg::gpio_t gpio_in, gpio_out, gpio_oe;
    int errors;
    logic [31:0] lfsr_state;
    // Word model of the on-chip memory
    soc_bus_pkg::data_t model [`SOC_BRAM_WORDS];

    soc_periph_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, got);
        if (got !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, got);
            errors++;
        end
    endtask

    // ------------------------------
    // Bus master
    // ------------------------------
    // Valid held until ready is seen at a rising edge
    task automatic bus_transfer(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t wd,
            input soc_bus_pkg::strb_t strb, output soc_bus_pkg::data_t rd, output logic err);
        int waited;
        @(negedge clk);
        {mem_valid, mem_addr, mem_wdata, mem_wstrb} = {1'b1, addr, wd, strb};
        waited = 0;
        @(negedge clk);
        // Completion edge at most SOC_BUS_TIMEOUT plus 2 cycles after valid
        while (!mem_ready && waited < `SOC_BUS_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!mem_ready) begin
            $display("Timeout waiting for mem_ready, address %h", addr);
            $display("Errors: %0d", errors + 1);
            $display("Done: errors found");
            $finish;
        end else begin
            rd  = mem_rdata;
            err = bus_error;
            @(posedge clk);
        end
    endtask

    task automatic bus_write(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t wd,
                             input soc_bus_pkg::strb_t strb);
        soc_bus_pkg::data_t rd;
        logic err;
        bus_transfer(addr, wd, strb, rd, err);
        check_value("bus_error", 32'h0, 32'(err));
    endtask

    task automatic bus_read(input soc_bus_pkg::addr_t addr, output soc_bus_pkg::data_t rd,
                            output logic err);
        bus_transfer(addr, '0, 4'h0, rd, err);
    endtask

    task automatic bus_idle();
        @(negedge clk);
        mem_valid = 1'b0;
        mem_wstrb = '0;
    endtask

    // Only strobed bytes change in the model, offsets wrap at the depth
    task automatic mem_write(input int idx, input soc_bus_pkg::data_t wd,
                             input soc_bus_pkg::strb_t strb);
        soc_bus_pkg::data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        bus_write({`SOC_BASE_BRAM, 22'(idx), 2'b00}, wd, strb);
        model[idx % `SOC_BRAM_WORDS] = (model[idx % `SOC_BRAM_WORDS] & ~mask) | (wd & mask);
    endtask

    task automatic mem_read_check(input int idx);
        soc_bus_pkg::data_t rd;
        logic err;
        bus_read({`SOC_BASE_BRAM, 22'(idx), 2'b00}, rd, err);
        check_value("mem_rdata", model[idx % `SOC_BRAM_WORDS], rd);
        check_value("bus_error", 32'h0, 32'(err));
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_reset();
        repeat (2) @(negedge clk);
        check_value("mem_ready", 32'h0, 32'(mem_ready));
        check_value("bus_error", 32'h0, 32'(bus_error));
        check_value("gpio_out", 32'h0, gpio_out);
        check_value("gpio_oe", 32'h0, gpio_oe);
    endtask

    task automatic test_mem_directed();
        // Fill, pattern from the whole word index
        for (int i = 0; i < `SOC_BRAM_WORDS; i++) begin
            mem_write(i, 32'h9e37_79b1 * (i + 1), 4'hf);
        end
        mem_write(5, 32'h1234_5678, 4'hf);
        mem_read_check(5);
        mem_write(5, 32'haabb_ccdd, 4'b0101);
        mem_read_check(5);
        mem_write(9, 32'h0102_0304, 4'b1000);
        mem_read_check(9);
        bus_idle();
    endtask

    task automatic test_mem_random();
        int idx;
        soc_bus_pkg::data_t wd;
        soc_bus_pkg::strb_t strb;
        for (int n = 0; n < 64; n++) begin
            // Ten offset bits, so some run past the depth
            idx = int'(rand_bits(10));
            if (rand_bits(1) != 0) begin
                wd   = rand_bits(32);
                strb = 4'(rand_bits(4));
                // Zero strobes would make it a read
                mem_write(idx, wd, (strb == 4'h0) ? 4'hf : strb);
            end else begin
                mem_read_check(idx);
            end
        end
        bus_idle();
    endtask

    task automatic test_gpio();
        soc_bus_pkg::data_t rd;
        soc_bus_pkg::gpio_t pins;
        logic err;
        bus_write({`SOC_BASE_GPIO, 24'h0}, 32'hdead_beef, 4'hf);
        bus_write({`SOC_BASE_GPIO, 24'h4}, 32'h5a5a_ffff, 4'b0011);
        bus_read({`SOC_BASE_GPIO, 24'h0}, rd, err);
        check_value("mem_rdata", 32'hdead_beef, rd);
        bus_read({`SOC_BASE_GPIO, 24'h4}, rd, err);
        check_value("mem_rdata", 32'h0000_ffff, rd);
        // Input word, write is acked and dropped
        bus_write({`SOC_BASE_GPIO, 24'h8}, 32'hffff_ffff, 4'hf);
        bus_idle();
        check_value("gpio_out", 32'hdead_beef, gpio_out);
        check_value("gpio_oe", 32'h0000_ffff, gpio_oe);
        pins    = rand_bits(32);
        gpio_in = pins;
        // Through the two-flop synchronizer
        repeat (3) @(negedge clk);
        bus_read({`SOC_BASE_GPIO, 24'h8}, rd, err);
        check_value("mem_rdata", pins, rd);
        bus_idle();
    endtask

    task automatic test_unmapped();
        soc_bus_pkg::data_t rd;
        logic err;
        bus_read(32'h0500_0010, rd, err);
        check_value("bus_error", 32'h1, 32'(err));
        check_value("mem_rdata", 32'h0, rd);
        // Memory still answers after the error
        mem_read_check(5);
        bus_idle();
    endtask

    initial begin
        errors     = 0;
        lfsr_state = 32'haedddaa1;
        reset      = 1'b1;
        {mem_valid, mem_addr, mem_wdata, mem_wstrb, gpio_in} = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        test_reset();
        test_mem_directed();
        test_mem_random();
        test_gpio();
        test_unmapped();
        // Bound checker failures
        errors += dut0.u_ret.chk0.fails;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+common
common/soc_bus_pkg.sv
common/mem_bus_if.sv
bram/bram_port.sv
gpio/gpio_port.sv
logic/bus_return_mux.sv
logic/soc_periph_top.sv
bench/soc_bus_checker.sv
bench/soc_periph_tb.sv
